// File: hdl/board_pkg.sv
package board_pkg;

    // ------------------------------------------------
    // Sizes

    localparam int w_sample = 24;  // INMP441 sample width
    localparam int n_digit  = 6;   // Enough hex digits for one sample

    // ------------------------------------------------
    // Types

    // Word select slot, matches the level of ws
    typedef enum logic
    {
        slot_left  = 1'b0,
        slot_right = 1'b1
    } slot_t;

    // Segments in abcdefgh order, a is the MSB and h is the dot
    typedef logic [7:0] seg_t;

    typedef enum logic [1:0]
    {
        rx_sync,  // One-bit delay after a ws change
        rx_data,  // Shifting data bits
        rx_pad    // Unused tail of the slot
    } rx_state_t;

    typedef enum logic [1:0]
    {
        hs_idle,
        hs_req,
        hs_wait_low
    } hs_state_t;

endpackage

// File: hdl/board_specific_top.sv
module board_specific_top
#(
    parameter int sck_div  = 8,   // Half period of mic_sck in clk cycles
    parameter int scan_div = 64,  // Clocks per scanned digit
    parameter int depth    = 4
)
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            sw_slot,

    output logic                            mic_sck,
    output logic                            mic_ws,
    input  logic                            mic_sd,

    output logic [6:0]                      hex0,
    output logic [6:0]                      hex1,
    output logic [6:0]                      hex2,
    output logic [6:0]                      hex3,
    output logic [6:0]                      hex4,
    output logic [6:0]                      hex5,
    output logic [board_pkg::n_digit - 1:0] dp_led
);

    logic                               sck_en;
    logic                               scan_en;
    board_pkg::seg_t                    abcdefgh;
    logic [board_pkg::n_digit - 1:0]    digit;

    sample_if rx_to_buf ();
    sample_if buf_to_scan ();

    // ------------------------------------------------
    // Enable strobes

    clk_enable_div #(.divide (sck_div))  i_sck_div  (.clk, .rst, .en (sck_en));
    clk_enable_div #(.divide (scan_div)) i_scan_div (.clk, .rst, .en (scan_en));

    // ------------------------------------------------
    // Microphone to display

    i2s_mic_receiver i_receiver
    (
        .clk     ( clk       ),
        .rst     ( rst       ),
        .sck_en  ( sck_en    ),
        .mic_sck ( mic_sck   ),
        .mic_ws  ( mic_ws    ),
        .mic_sd  ( mic_sd    ),
        .smp     ( rx_to_buf )
    );

    sample_buffer #(.depth (depth)) i_buffer
    (
        .clk ( clk         ),
        .rst ( rst         ),
        .wr  ( rx_to_buf   ),
        .rd  ( buf_to_scan )
    );

    seg7_scanner i_scanner
    (
        .clk      ( clk                                ),
        .rst      ( rst                                ),
        .scan_en  ( scan_en                            ),
        .slot_sel ( board_pkg::slot_t' (sw_slot)       ),
        .smp      ( buf_to_scan                        ),
        .abcdefgh ( abcdefgh                           ),
        .digit    ( digit                              )
    );

    static_hex_latch i_hex_latch
    (
        .clk, .rst, .abcdefgh, .digit,
        .hex0, .hex1, .hex2, .hex3, .hex4, .hex5,
        .dp_led
    );

endmodule

// File: hdl/clk_enable_div.sv
module clk_enable_div
#(
    parameter int divide = 8
)
(
    input  logic clk,
    input  logic rst,
    output logic en
);

    localparam int w_cnt = (divide > 1) ? $clog2 (divide) : 1;

    logic [w_cnt - 1:0] cnt;

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            cnt <= '0;
            en  <= 1'b0;
        end
        else if (cnt == w_cnt' (divide - 1))
        begin
            cnt <= '0;
            en  <= 1'b1;  // One clock wide
        end
        else
        begin
            cnt <= cnt + 1'b1;
            en  <= 1'b0;
        end

endmodule

// File: hdl/i2s_mic_receiver.sv
module i2s_mic_receiver
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sck_en,

    output logic        mic_sck,
    output logic        mic_ws,
    input  logic        mic_sd,

    sample_if.producer  smp
);

    localparam int w = board_pkg::w_sample;

    logic [4:0]             bit_cnt;  // Falling sck edges since the last ws change
    logic [w - 1:0]         shift_reg;
    logic                   sck_rise;
    logic                   sck_fall;
    logic                   word_done;
    logic                   take;

    board_pkg::rx_state_t   rx_state;
    board_pkg::hs_state_t   hs_state;

    assign sck_rise  = sck_en & ~ mic_sck;
    assign sck_fall  = sck_en &   mic_sck;

    // Last data bit arrives on the rising edge at count 24
    assign word_done = sck_rise && rx_state == board_pkg::rx_data
                       && bit_cnt == 5' (w);
    assign take      = word_done && hs_state == board_pkg::hs_idle;  // Else dropped

    // ------------------------------------------------
    // Serial clock and word select

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            mic_sck <= 1'b0;
            mic_ws  <= 1'b0;
            bit_cnt <= '0;
        end
        else if (sck_en)
        begin
            mic_sck <= ~ mic_sck;

            if (sck_fall)
            begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 5'd31)
                    mic_ws <= ~ mic_ws;  // Slot is 32 sck periods
            end
        end

    // ------------------------------------------------
    // Data field FSM

    always_ff @ (posedge clk or posedge rst)
        if (rst)
            rx_state <= board_pkg::rx_sync;
        else
            case (rx_state)
            board_pkg::rx_sync : if (sck_rise)  rx_state <= board_pkg::rx_data;
            board_pkg::rx_data : if (word_done) rx_state <= board_pkg::rx_pad;
            default:
                if (sck_fall && bit_cnt == 5'd31)
                    rx_state <= board_pkg::rx_sync;
            endcase

    always_ff @ (posedge clk)
        if (sck_rise && rx_state == board_pkg::rx_data)
            shift_reg <= { shift_reg [w - 2:0], mic_sd };  // MSB first

    always_ff @ (posedge clk)
        if (take)
        begin
            smp.value <= { shift_reg [w - 2:0], mic_sd };
            smp.slot  <= board_pkg::slot_t' (mic_ws);
        end

    // ------------------------------------------------
    // Producer side of the handshake

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            hs_state <= board_pkg::hs_idle;
            smp.req  <= 1'b0;
        end
        else
            case (hs_state)
            board_pkg::hs_idle:
                if (take)
                begin
                    smp.req  <= 1'b1;
                    hs_state <= board_pkg::hs_req;
                end
            board_pkg::hs_req:
                if (smp.ack)
                begin
                    smp.req  <= 1'b0;
                    hs_state <= board_pkg::hs_wait_low;
                end
            default:
                if (! smp.ack)
                    hs_state <= board_pkg::hs_idle;
            endcase

endmodule

// File: hdl/sample_buffer.sv
module sample_buffer
#(
    parameter int depth = 4  // Power of two
)
(
    input  logic        clk,
    input  logic        rst,
    sample_if.consumer  wr,
    sample_if.producer  rd
);

    localparam int w_ptr = $clog2 (depth);

    logic [board_pkg::w_sample - 1:0]   mem_value [depth];
    board_pkg::slot_t                   mem_slot  [depth];

    logic [w_ptr:0]         wr_ptr;  // Extra MSB tells full from empty
    logic [w_ptr:0]         rd_ptr;
    logic                   full;
    logic                   empty;
    logic                   push;
    logic                   pop;

    board_pkg::hs_state_t   wr_state;
    board_pkg::hs_state_t   rd_state;

    assign empty = wr_ptr == rd_ptr;
    assign full  = (wr_ptr - rd_ptr) == (w_ptr + 1)' (depth);
    assign push  = wr_state == board_pkg::hs_idle && wr.req && ! full;  // Full withholds ack
    assign pop   = rd_state == board_pkg::hs_req  && rd.ack;

    always_ff @ (posedge clk)
        if (push)
        begin
            mem_value [wr_ptr [w_ptr - 1:0]] <= wr.value;
            mem_slot  [wr_ptr [w_ptr - 1:0]] <= wr.slot;
        end

    assign rd.value = mem_value [rd_ptr [w_ptr - 1:0]];  // Head of the queue
    assign rd.slot  = mem_slot  [rd_ptr [w_ptr - 1:0]];

    // ------------------------------------------------
    // Write side, consumer

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            wr_state <= board_pkg::hs_idle;
            wr.ack   <= 1'b0;
            wr_ptr   <= '0;
        end
        else if (push)
        begin
            wr.ack   <= 1'b1;
            wr_ptr   <= wr_ptr + 1'b1;
            wr_state <= board_pkg::hs_wait_low;
        end
        else if (wr_state == board_pkg::hs_wait_low && ! wr.req)
        begin
            wr.ack   <= 1'b0;
            wr_state <= board_pkg::hs_idle;
        end

    // ------------------------------------------------
    // Read side, producer

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            rd_state <= board_pkg::hs_idle;
            rd.req   <= 1'b0;
            rd_ptr   <= '0;
        end
        else
            case (rd_state)
            board_pkg::hs_idle:
                if (! empty)
                begin
                    rd.req   <= 1'b1;
                    rd_state <= board_pkg::hs_req;
                end
            board_pkg::hs_req:
                if (pop)
                begin
                    rd.req   <= 1'b0;
                    rd_ptr   <= rd_ptr + 1'b1;
                    rd_state <= board_pkg::hs_wait_low;
                end
            default:
                if (! rd.ack)
                    rd_state <= board_pkg::hs_idle;
            endcase

endmodule

// File: hdl/sample_if.sv
interface sample_if;

    logic                               req;
    logic                               ack;
    logic [board_pkg::w_sample - 1:0]   value;
    board_pkg::slot_t                   slot;

    // Four-phase handshake, value and slot stable while req is high

    modport producer
    (
        output req, value, slot,
        input  ack
    );

    modport consumer
    (
        input  req, value, slot,
        output ack
    );

endinterface

// File: hdl/seg7_scanner.sv
module seg7_scanner
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            scan_en,
    input  board_pkg::slot_t                slot_sel,
    sample_if.consumer                      smp,
    output board_pkg::seg_t                 abcdefgh,
    output logic [board_pkg::n_digit - 1:0] digit
);

    localparam int w_idx = $clog2 (board_pkg::n_digit);

    logic [board_pkg::w_sample - 1:0]   shown;
    logic [w_idx - 1:0]                 idx;
    logic [w_idx - 1:0]                 next_idx;
    logic [3:0]                         nibble;
    logic                               dot;

    // Active-high segments abcdefg of one hex nibble
    function automatic logic [6:0] hex_pattern (input logic [3:0] n);
        case (n)
        4'h0:    return 7'b1111110;
        4'h1:    return 7'b0110000;
        4'h2:    return 7'b1101101;
        4'h3:    return 7'b1111001;
        4'h4:    return 7'b0110011;
        4'h5:    return 7'b1011011;
        4'h6:    return 7'b1011111;
        4'h7:    return 7'b1110000;
        4'h8:    return 7'b1111111;
        4'h9:    return 7'b1111011;
        4'ha:    return 7'b1110111;
        4'hb:    return 7'b0011111;
        4'hc:    return 7'b1001110;
        4'hd:    return 7'b0111101;
        4'he:    return 7'b1001111;
        default: return 7'b1000111;
        endcase
    endfunction

    // ------------------------------------------------
    // Sample intake, ack every sample one clock after req

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            smp.ack <= 1'b0;
            shown   <= '0;
        end
        else if (smp.req && ! smp.ack)
        begin
            smp.ack <= 1'b1;
            if (smp.slot == slot_sel)
                shown <= smp.value;  // Other slot is discarded
        end
        else if (! smp.req)
            smp.ack <= 1'b0;

    // ------------------------------------------------
    // Digit scan

    // Wrap after the last digit, also start here after reset
    assign next_idx = (digit == '0 || idx == w_idx' (board_pkg::n_digit - 1))
                      ? '0 : idx + 1'b1;
    assign nibble   = shown [next_idx * 4 +: 4];
    assign dot      = next_idx == '0 && slot_sel == board_pkg::slot_right;

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            idx      <= '0;
            digit    <= '0;
            abcdefgh <= '0;
        end
        else if (scan_en)
        begin
            idx             <= next_idx;
            digit           <= '0;
            digit[next_idx] <= 1'b1;
            abcdefgh        <= { hex_pattern (nibble), dot };
        end

endmodule

// File: hdl/static_hex_latch.sv
module static_hex_latch
(
    input  logic                            clk,
    input  logic                            rst,
    input  board_pkg::seg_t                 abcdefgh,
    input  logic [board_pkg::n_digit - 1:0] digit,

    output logic [6:0]                      hex0,
    output logic [6:0]                      hex1,
    output logic [6:0]                      hex2,
    output logic [6:0]                      hex3,
    output logic [6:0]                      hex4,
    output logic [6:0]                      hex5,
    output logic [board_pkg::n_digit - 1:0] dp_led
);

    board_pkg::seg_t    hgfedcba;
    logic [6:0]         hex_r [board_pkg::n_digit];  // Active low, bit 0 is segment a

    always_comb
        for (int i = 0; i < $bits (abcdefgh); i++)
            hgfedcba[i] = abcdefgh[$bits (abcdefgh) - 1 - i];

    // Each digit keeps its last pattern until its strobe comes again
    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            for (int i = 0; i < board_pkg::n_digit; i++)
                hex_r[i] <= '1;  // Blank
            dp_led <= '0;
        end
        else
        begin
            for (int i = 0; i < board_pkg::n_digit; i++)
                if (digit[i])
                begin
                    hex_r[i]  <= ~ hgfedcba[6:0];
                    dp_led[i] <= hgfedcba[7];  // Dot drives an LED, high active
                end
        end

    assign hex0 = hex_r[0];
    assign hex1 = hex_r[1];
    assign hex2 = hex_r[2];
    assign hex3 = hex_r[3];
    assign hex4 = hex_r[4];
    assign hex5 = hex_r[5];

endmodule

// File: mic_hex_display.f
hdl/board_pkg.sv
hdl/sample_if.sv
hdl/clk_enable_div.sv
hdl/i2s_mic_receiver.sv
hdl/sample_buffer.sv
hdl/seg7_scanner.sv
hdl/static_hex_latch.sv
hdl/board_specific_top.sv
sim/tb_checker.sv
sim/tb_board_top.sv

// File: sim/tb_board_top.sv
module tb_board_top;

    localparam int sck_div    = 8;
    localparam int scan_div   = 64;
    localparam int depth      = 4;
    localparam int frame_clks = 64 * 2 * sck_div;
    localparam int w          = board_pkg::w_sample;
    localparam int n          = board_pkg::n_digit;

    logic               clk;
    logic               rst;
    logic               sw_slot;
    logic               mic_sck;
    logic               mic_ws;
    logic               mic_sd;
    logic [6:0]         hex0, hex1, hex2, hex3, hex4, hex5;
    logic [n - 1:0]     dp_led;

    logic [w - 1:0]     left_word;
    logic [w - 1:0]     right_word;
    logic [w - 1:0]     out_word;  // Word being shifted out by the mic model
    logic [7 * n - 1:0] exp_hex;
    logic [n - 1:0]     exp_dp;
    logic               prev_sck;
    logic               prev_ws;
    int                 bit_pos;
    int                 frame_cnt;
    int                 start_frame;
    int                 seed;
    int                 n_pass;
    int                 n_fail;

    board_specific_top #(.sck_div (sck_div), .scan_div (scan_div), .depth (depth)) u_dut
    (
        .clk, .rst, .sw_slot, .mic_sck, .mic_ws, .mic_sd,
        .hex0, .hex1, .hex2, .hex3, .hex4, .hex5, .dp_led
    );

    tb_checker #(.sck_div (sck_div), .scan_div (scan_div)) u_check
    (
        .clk, .rst, .mic_sck, .mic_ws,
        .hex_all ({ hex5, hex4, hex3, hex2, hex1, hex0 }),
        .dp_led, .exp_hex, .exp_dp, .n_pass, .n_fail
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------
    // Reference model

    // Active-low pattern with segment a in bit 0
    function automatic logic [6:0] seg_of (input logic [3:0] nibble);
        logic [6:0] table_lo [16];
        table_lo = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                     7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
        return table_lo[nibble];
    endfunction

    function automatic logic [7 * n - 1:0] expected_hex (input logic [w - 1:0] value);
        logic [7 * n - 1:0] result;
        for (int d = 0; d < n; d++)
            result[7 * d +: 7] = seg_of(value[4 * d +: 4]);  // Digit 0 is the low nibble
        return result;
    endfunction

    task automatic set_expect (input logic [w - 1:0] value, input logic right);
        exp_hex    = expected_hex(value);
        exp_dp     = '0;
        exp_dp[0]  = right;  // Dot marks the right slot
    endtask

    // ------------------------------------------------
    // I2S microphone model drives data on the falling sck edge

    always @(posedge clk)
    begin
        #2;
        if (rst)
        begin
            prev_sck = 1'b0;
            prev_ws  = 1'b0;
            bit_pos  = 0;
            mic_sd   = 1'b0;
        end
        else if (prev_sck && !mic_sck)
        begin
            if (mic_ws != prev_ws)
            begin
                bit_pos = 0;
                if (!mic_ws)
                    frame_cnt++;  // Left slot opens a frame
            end
            else
                bit_pos++;
            if (bit_pos == 1)
                out_word = mic_ws ? right_word : left_word;
            else
                out_word = out_word << 1;
            mic_sd  = (bit_pos >= 1 && bit_pos <= w) ? out_word[w - 1] : 1'b0;
            prev_ws = mic_ws;
        end
        if (!rst)
            prev_sck = mic_sck;
    end

    // ------------------------------------------------
    // Run control

    task automatic abort_run (input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $finish;
    endtask

    task automatic wait_until_frame (input int target);
        int waited;
        waited = 0;
        while (frame_cnt < target && waited < 6 * frame_clks)
        begin
            @(negedge clk);
            waited++;
        end
        if (frame_cnt < target)
            abort_run("Timeout while waiting for the next I2S frame from the DUT");
        else
        begin
            @(posedge clk);
            #2;
        end
    endtask

    initial
    begin
        seed       = 13;
        rst        = 1'b1;
        sw_slot    = 1'b0;
        mic_sd     = 1'b0;
        frame_cnt  = 0;
        left_word  = '0;
        right_word = '0;
        out_word   = '0;
        exp_hex    = '1;
        exp_dp     = '0;

        repeat (10) @(posedge clk);
        #2 rst = 1'b0;

        // Blank display right after reset
        exp_hex = '1;
        exp_dp  = '0;
        u_check.check_now("reset state");

        left_word  = 24'h7e41d9;
        right_word = 24'hb5028c;
        set_expect(left_word, 1'b0);
        u_check.check_display("constant left sample");

        @(posedge clk);
        #2 sw_slot = 1'b1;
        set_expect(right_word, 1'b1);
        u_check.check_display("right slot selected");

        @(posedge clk);
        #2 sw_slot = 1'b0;
        set_expect(left_word, 1'b0);
        u_check.check_display("left slot restored");

        wait_until_frame(frame_cnt + 1);
        for (int i = 0; i < 8; i++)
        begin
            left_word   = $random(seed);
            right_word  = $random(seed);
            sw_slot     = i % 2;
            start_frame = frame_cnt;
            set_expect(sw_slot ? right_word : left_word, sw_slot);
            u_check.check_display($sformatf("random pair %0d", i));
            wait_until_frame(start_frame + 4);  // Pair stays for 4 frames
        end

        u_check.report_timing("I2S timing");
        @(negedge clk);

        $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: sim/tb_checker.sv
module tb_checker
#(
    parameter int sck_div  = 8,
    parameter int scan_div = 64
)
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                mic_sck,
    input  logic                                mic_ws,
    input  logic [7 * board_pkg::n_digit - 1:0] hex_all,  // hex5 down to hex0
    input  logic [board_pkg::n_digit - 1:0]     dp_led,
    input  logic [7 * board_pkg::n_digit - 1:0] exp_hex,
    input  logic [board_pkg::n_digit - 1:0]     exp_dp,
    output int                                  n_pass,
    output int                                  n_fail
);

    localparam int frame_clks = 64 * 2 * sck_div;
    localparam int scan_clks  = board_pkg::n_digit * scan_div;

    int     half_cnt;
    int     rise_cnt;
    int     ws_changes;
    int     timing_err;
    logic   prev_sck;
    logic   prev_ws;
    logic   sck_seen;

    initial
    begin
        n_pass     = 0;
        n_fail     = 0;
        timing_err = 0;
    end

    function automatic logic display_matches ();
        return hex_all === exp_hex && dp_led === exp_dp;
    endfunction

    // ------------------------------------------------
    // Display checks

    task automatic compare_outputs (input string name);
        int errors;
        errors = 0;
        for (int d = 0; d < board_pkg::n_digit; d++)
            if (hex_all[7 * d +: 7] !== exp_hex[7 * d +: 7])
            begin
                $display("Error at %0t: hex%0d expected %b, got %b",
                         $time, d, exp_hex[7 * d +: 7], hex_all[7 * d +: 7]);
                errors++;
            end
        if (dp_led !== exp_dp)
        begin
            $display("Error at %0t: dp_led expected %b, got %b", $time, exp_dp, dp_led);
            errors++;
        end
        if (errors == 0)
        begin
            n_pass++;
            $display("Test %s: ok", name);
        end
        else
        begin
            n_fail++;
            $display("Test %s: %0d mismatches", name, errors);
        end
    endtask

    task automatic check_now (input string name);
        @(negedge clk);
        compare_outputs(name);
    endtask

    // Wait for the display to settle, then it has to hold for 3 scans
    task automatic check_display (input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!display_matches() && waited < 4 * frame_clks)
        begin
            @(negedge clk);
            waited++;
        end
        if (!display_matches())
            $display("Test %s: display did not settle within 4 frames", name);
        waited = 0;
        while (display_matches() && waited < 3 * scan_clks)
        begin
            @(negedge clk);
            waited++;
        end
        compare_outputs(name);
    endtask

    // ------------------------------------------------
    // I2S timing monitor

    always @(negedge clk)
    begin
        if (rst)
        begin
            prev_sck   = 1'b0;
            prev_ws    = 1'b0;
            sck_seen   = 1'b0;  // First half period after reset is not measured
            half_cnt   = 0;
            rise_cnt   = 0;
            ws_changes = 0;
        end
        else
        begin
            half_cnt++;
            if (mic_sck !== prev_sck)
            begin
                if (sck_seen && half_cnt != sck_div)
                begin
                    $display("Error at %0t: mic_sck half period expected %0d, got %0d",
                             $time, sck_div, half_cnt);
                    timing_err++;
                end
                sck_seen = 1'b1;
                half_cnt = 0;
                if (mic_sck)
                    rise_cnt++;
            end
            if (mic_ws !== prev_ws)
            begin
                if (ws_changes > 0 && rise_cnt != 32)
                begin
                    $display("Error at %0t: mic_ws slot length expected %0d, got %0d",
                             $time, 32, rise_cnt);
                    timing_err++;
                end
                ws_changes++;
                rise_cnt = 0;
            end
            prev_sck = mic_sck;
            prev_ws  = mic_ws;
        end
    end

    task automatic report_timing (input string name);
        if (ws_changes < 2)
        begin
            n_fail++;
            $display("Test %s: mic_ws did not toggle often enough to measure", name);
        end
        else if (timing_err == 0)
        begin
            n_pass++;
            $display("Test %s: ok", name);
        end
        else
        begin
            n_fail++;
            $display("Test %s: %0d timing errors", name, timing_err);
        end
    endtask

endmodule
